//--- source/exec_pkg.sv
`default_nettype none

package exec_pkg;

    localparam int XLEN = 64;
    localparam int REGNO_W = 5;

    typedef logic [XLEN-1:0] reg_t;
    typedef logic [REGNO_W-1:0] regno_t;
    typedef logic [XLEN-1:0] addr_t;
    typedef logic [5:0] shamt_t;
    typedef logic [1:0] stall_cnt_t;

    // OP_NOP must stay at zero so a cleared result reads as a bubble
    typedef enum logic [5:0] {
        OP_NOP = 6'd0,
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        ADDI,
        SLTI,
        SLTIU,
        XORI,
        ORI,
        ANDI,
        SLLI,
        SRLI,
        SRAI,
        ADDW,
        SUBW,
        SLLW,
        SRLW,
        SRAW,
        ADDIW,
        SLLIW,
        SRLIW,
        SRAIW,
        LUI,
        AUIPC,
        JAL,
        JALR,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        LOAD,
        STORE
    } alu_op_e;

    typedef struct packed {
        alu_op_e op;
        regno_t rd;
        regno_t rs1;
        regno_t rs2;
        reg_t rs1_value;
        reg_t rs2_value;
        reg_t imm;
        addr_t pc;
    } ex_issue_t;

    // View of a later stage, used for forwarding
    typedef struct packed {
        regno_t rd;
        logic writes_rd;
        logic is_load;
        reg_t result;
    } bypass_t;

    typedef struct packed {
        alu_op_e op;
        regno_t rd;
        reg_t alu_result;
        reg_t store_value;
        addr_t target;
        logic writes_rd;
        logic is_load;
        logic branch_taken;
    } ex_result_t;

endpackage

`default_nettype wire

//--- source/operand_forward.sv
`timescale 1ns/100ps
`default_nettype none

module operand_forward
(
    input wire exec_pkg::ex_issue_t issue,
    input wire exec_pkg::bypass_t alu_fwd,
    input wire exec_pkg::bypass_t mem_fwd,
    input wire exec_pkg::bypass_t wb_fwd,
    input wire exec_pkg::reg_t mem_data,
    input wire exec_pkg::stall_cnt_t stall_cnt,
    output exec_pkg::reg_t op_a,
    output exec_pkg::reg_t op_b,
    output logic hazard
);

    logic rs1_load_hit;
    logic rs2_load_hit;

    // Producer one ahead is a load, so its data is not there yet
    function automatic logic load_match(input exec_pkg::regno_t rs);
        return (rs != '0) && (rs == alu_fwd.rd) && alu_fwd.is_load;
    endfunction

    function automatic exec_pkg::reg_t forward(
        input exec_pkg::regno_t rs,
        input exec_pkg::reg_t issued
    );
        exec_pkg::reg_t value;
        if (rs == '0)
        begin
            value = issued;
        end
        else if (rs == alu_fwd.rd && alu_fwd.is_load)
        begin
            // Only used after the stall, when the load sits in memory
            value = mem_data;
        end
        else if (rs == alu_fwd.rd && alu_fwd.writes_rd)
        begin
            value = alu_fwd.result;
        end
        else if (rs == mem_fwd.rd && mem_fwd.is_load)
        begin
            value = mem_data;
        end
        else if (rs == mem_fwd.rd && mem_fwd.writes_rd)
        begin
            value = mem_fwd.result;
        end
        else if (rs == wb_fwd.rd && wb_fwd.writes_rd)
        begin
            value = wb_fwd.result;
        end
        else
        begin
            value = issued;
        end
        return value;
    endfunction

    always_comb
    begin
        rs1_load_hit = load_match(issue.rs1);
        rs2_load_hit = load_match(issue.rs2);
        op_a = forward(issue.rs1, issue.rs1_value);
        op_b = forward(issue.rs2, issue.rs2_value);
        hazard = (stall_cnt == '0) && (rs1_load_hit || rs2_load_hit);
    end

    // The register stage stalls at most once per instruction
    always_comb
    begin
        assert (stall_cnt <= exec_pkg::stall_cnt_t'(1))
        else $error("stall_cnt out of range: %0d", stall_cnt);
    end

endmodule

`default_nettype wire

//--- source/int_alu.sv
`timescale 1ns/100ps
`default_nettype none

module int_alu
#(
    parameter int XLEN_P = exec_pkg::XLEN
)
(
    input wire exec_pkg::alu_op_e op,
    input wire exec_pkg::reg_t op_a,
    input wire exec_pkg::reg_t op_b,
    input wire exec_pkg::reg_t imm,
    input wire exec_pkg::addr_t pc,
    output exec_pkg::reg_t alu_result,
    output logic writes_rd,
    output logic is_load
);

    // 63 on RV64, 31 on RV32
    localparam exec_pkg::shamt_t SHAMT_MASK = exec_pkg::shamt_t'(XLEN_P - 1);

    exec_pkg::shamt_t sh_reg;
    exec_pkg::shamt_t sh_imm;

    if (XLEN_P != 64 && XLEN_P != 32)
    begin : g_bad_xlen
        $error("int_alu: XLEN_P must be 64 or 32");
    end

    function automatic exec_pkg::reg_t sext_word(input logic [31:0] w);
        return {{(exec_pkg::XLEN - 32){w[31]}}, w};
    endfunction

    assign sh_reg = op_b[5:0] & SHAMT_MASK;
    assign sh_imm = imm[5:0] & SHAMT_MASK;

    always_comb
    begin
        alu_result = '0;
        writes_rd = 1'b1;
        is_load = 1'b0;
        unique case (op)
            exec_pkg::ADD:   alu_result = op_a + op_b;
            exec_pkg::SUB:   alu_result = op_a - op_b;
            exec_pkg::SLL:   alu_result = op_a << sh_reg;
            exec_pkg::SLT:   alu_result = exec_pkg::reg_t'($signed(op_a) < $signed(op_b));
            exec_pkg::SLTU:  alu_result = exec_pkg::reg_t'(op_a < op_b);
            exec_pkg::XOR:   alu_result = op_a ^ op_b;
            exec_pkg::SRL:   alu_result = op_a >> sh_reg;
            exec_pkg::SRA:   alu_result = $signed(op_a) >>> sh_reg;
            exec_pkg::OR:    alu_result = op_a | op_b;
            exec_pkg::AND:   alu_result = op_a & op_b;
            exec_pkg::ADDI:  alu_result = op_a + imm;
            exec_pkg::SLTI:  alu_result = exec_pkg::reg_t'($signed(op_a) < $signed(imm));
            exec_pkg::SLTIU: alu_result = exec_pkg::reg_t'(op_a < imm);
            exec_pkg::XORI:  alu_result = op_a ^ imm;
            exec_pkg::ORI:   alu_result = op_a | imm;
            exec_pkg::ANDI:  alu_result = op_a & imm;
            exec_pkg::SLLI:  alu_result = op_a << sh_imm;
            exec_pkg::SRLI:  alu_result = op_a >> sh_imm;
            exec_pkg::SRAI:  alu_result = $signed(op_a) >>> sh_imm;
            // Word forms work on the low half and sign-extend bit 31
            exec_pkg::ADDW:  alu_result = sext_word(op_a[31:0] + op_b[31:0]);
            exec_pkg::SUBW:  alu_result = sext_word(op_a[31:0] - op_b[31:0]);
            exec_pkg::SLLW:  alu_result = sext_word(op_a[31:0] << op_b[4:0]);
            exec_pkg::SRLW:  alu_result = sext_word(op_a[31:0] >> op_b[4:0]);
            exec_pkg::SRAW:  alu_result = sext_word($signed(op_a[31:0]) >>> op_b[4:0]);
            exec_pkg::ADDIW: alu_result = sext_word(op_a[31:0] + imm[31:0]);
            exec_pkg::SLLIW: alu_result = sext_word(op_a[31:0] << imm[4:0]);
            exec_pkg::SRLIW: alu_result = sext_word(op_a[31:0] >> imm[4:0]);
            exec_pkg::SRAIW: alu_result = sext_word($signed(op_a[31:0]) >>> imm[4:0]);
            exec_pkg::LUI:   alu_result = imm;
            exec_pkg::AUIPC: alu_result = pc + imm;
            // Link value
            exec_pkg::JAL,
            exec_pkg::JALR:  alu_result = pc + exec_pkg::reg_t'(4);
            exec_pkg::LOAD:
            begin
                alu_result = op_a + imm;
                is_load = 1'b1;
            end
            exec_pkg::STORE:
            begin
                alu_result = op_a + imm;
                writes_rd = 1'b0;
            end
            default:
            begin
                // Branches and bubbles
                writes_rd = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/branch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module branch_unit
(
    input wire exec_pkg::alu_op_e op,
    input wire exec_pkg::reg_t op_a,
    input wire exec_pkg::reg_t op_b,
    input wire exec_pkg::reg_t imm,
    input wire exec_pkg::addr_t pc,
    output logic branch_taken,
    output exec_pkg::addr_t target
);

    exec_pkg::addr_t jalr_sum;

    assign jalr_sum = op_a + imm;

    always_comb
    begin
        unique case (op)
            exec_pkg::BEQ:  branch_taken = (op_a == op_b);
            exec_pkg::BNE:  branch_taken = (op_a != op_b);
            exec_pkg::BLT:  branch_taken = ($signed(op_a) < $signed(op_b));
            exec_pkg::BGE:  branch_taken = ($signed(op_a) >= $signed(op_b));
            exec_pkg::BLTU: branch_taken = (op_a < op_b);
            exec_pkg::BGEU: branch_taken = (op_a >= op_b);
            exec_pkg::JAL,
            exec_pkg::JALR: branch_taken = 1'b1;
            default:        branch_taken = 1'b0;
        endcase
    end

    always_comb
    begin
        if (op == exec_pkg::JALR)
        begin
            // Bit 0 of the jump target is always dropped
            target = {jalr_sum[exec_pkg::XLEN-1:1], 1'b0};
        end
        else if (branch_taken)
        begin
            target = pc + imm;
        end
        else
        begin
            target = pc + exec_pkg::addr_t'(4);
        end
    end

endmodule

`default_nettype wire

//--- source/ex_mem_register.sv
`timescale 1ns/100ps
`default_nettype none

module ex_mem_register
(
    input wire logic clk,
    input wire logic reset,
    input wire logic syscall_flush,
    input wire logic branch_flush,
    input wire logic issue_valid,
    input wire logic hazard,
    input wire exec_pkg::ex_result_t next,
    output exec_pkg::ex_result_t result,
    output logic issue_ready,
    output exec_pkg::stall_cnt_t stall_cnt
);

    logic accept;

    assign issue_ready = !hazard;
    assign accept = issue_valid && issue_ready;

    always_ff @(posedge clk)
    begin
        if (reset || syscall_flush)
        begin
            stall_cnt <= '0;
            result <= '0;
        end
        else if (accept)
        begin
            stall_cnt <= '0;
            // Squashed path becomes a bubble
            if (branch_flush)
            begin
                result <= '0;
            end
            else
            begin
                result <= next;
            end
        end
        else if (branch_flush)
        begin
            stall_cnt <= '0;
        end
        else if (issue_valid && hazard)
        begin
            stall_cnt <= exec_pkg::stall_cnt_t'(1);
        end
    end

    // Only control opcodes may leave with a taken branch
    assert property (@(posedge clk) disable iff (reset)
        result.branch_taken |-> result.op inside {exec_pkg::JAL, exec_pkg::JALR,
            exec_pkg::BEQ, exec_pkg::BNE, exec_pkg::BLT, exec_pkg::BGE,
            exec_pkg::BLTU, exec_pkg::BGEU})
    else $error("branch_taken set for op %s", result.op.name());

    // Load-use stall lasts one cycle
    assert property (@(posedge clk) disable iff (reset)
        (issue_valid && !issue_ready && !branch_flush && !syscall_flush) |=> issue_ready)
    else $error("issue_ready low for more than one cycle");

endmodule

`default_nettype wire

//--- source/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage
#(
    parameter int XLEN_P = exec_pkg::XLEN
)
(
    input wire logic clk,
    input wire logic reset,
    input wire logic issue_valid,
    input wire exec_pkg::ex_issue_t issue,
    input wire exec_pkg::bypass_t alu_fwd,
    input wire exec_pkg::bypass_t mem_fwd,
    input wire exec_pkg::bypass_t wb_fwd,
    input wire exec_pkg::reg_t mem_data,
    input wire logic branch_flush,
    input wire logic syscall_flush,
    output logic issue_ready,
    output exec_pkg::ex_result_t result
);

    exec_pkg::reg_t op_a;
    exec_pkg::reg_t op_b;
    exec_pkg::reg_t alu_result;
    exec_pkg::addr_t target;
    exec_pkg::stall_cnt_t stall_cnt;
    exec_pkg::ex_result_t next;
    logic hazard;
    logic writes_rd;
    logic is_load;
    logic branch_taken;

    operand_forward u_operand_forward (
        .issue     (issue),
        .alu_fwd   (alu_fwd),
        .mem_fwd   (mem_fwd),
        .wb_fwd    (wb_fwd),
        .mem_data  (mem_data),
        .stall_cnt (stall_cnt),
        .op_a      (op_a),
        .op_b      (op_b),
        .hazard    (hazard)
    );

    int_alu #(
        .XLEN_P (XLEN_P)
    ) u_int_alu (
        .op         (issue.op),
        .op_a       (op_a),
        .op_b       (op_b),
        .imm        (issue.imm),
        .pc         (issue.pc),
        .alu_result (alu_result),
        .writes_rd  (writes_rd),
        .is_load    (is_load)
    );

    branch_unit u_branch_unit (
        .op           (issue.op),
        .op_a         (op_a),
        .op_b         (op_b),
        .imm          (issue.imm),
        .pc           (issue.pc),
        .branch_taken (branch_taken),
        .target       (target)
    );

    always_comb
    begin
        next.op = issue.op;
        next.rd = issue.rd;
        next.alu_result = alu_result;
        // Forwarded rs2 is the store data
        next.store_value = op_b;
        next.target = target;
        next.writes_rd = writes_rd;
        next.is_load = is_load;
        next.branch_taken = branch_taken;
    end

    ex_mem_register u_ex_mem_register (
        .clk           (clk),
        .reset         (reset),
        .syscall_flush (syscall_flush),
        .branch_flush  (branch_flush),
        .issue_valid   (issue_valid),
        .hazard        (hazard),
        .next          (next),
        .result        (result),
        .issue_ready   (issue_ready),
        .stall_cnt     (stall_cnt)
    );

endmodule

`default_nettype wire

//--- sim/exec_model.svh
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// Operand after forwarding, for a source register without a pending hazard
function automatic exec_pkg::reg_t select_operand(
    input exec_pkg::regno_t rs,
    input exec_pkg::reg_t issued,
    input exec_pkg::bypass_t ex,
    input exec_pkg::bypass_t mem,
    input exec_pkg::bypass_t wb,
    input exec_pkg::reg_t load_data
);
    if (rs == '0)
        return issued;
    // A load one ahead has reached memory by the time this is accepted
    if (rs == ex.rd && ex.is_load)
        return load_data;
    if (rs == ex.rd && ex.writes_rd)
        return ex.result;
    if (rs == mem.rd && mem.is_load)
        return load_data;
    if (rs == mem.rd && mem.writes_rd)
        return mem.result;
    if (rs == wb.rd && wb.writes_rd)
        return wb.result;
    return issued;
endfunction

function automatic logic has_load_use(
    input exec_pkg::ex_issue_t ins,
    input exec_pkg::bypass_t ex
);
    return ex.is_load && ((ins.rs1 != '0 && ins.rs1 == ex.rd) ||
                          (ins.rs2 != '0 && ins.rs2 == ex.rd));
endfunction

function automatic exec_pkg::addr_t resolve_branch(
    input exec_pkg::alu_op_e op,
    input exec_pkg::reg_t a,
    input exec_pkg::reg_t b,
    input exec_pkg::reg_t imm,
    input exec_pkg::addr_t pc,
    output logic taken
);
    case (op)
        exec_pkg::BEQ:  taken = (a == b);
        exec_pkg::BNE:  taken = (a != b);
        exec_pkg::BLT:  taken = ($signed(a) < $signed(b));
        exec_pkg::BGE:  taken = ($signed(a) >= $signed(b));
        exec_pkg::BLTU: taken = (a < b);
        exec_pkg::BGEU: taken = (a >= b);
        exec_pkg::JAL,
        exec_pkg::JALR: taken = 1'b1;
        default:        taken = 1'b0;
    endcase
    if (op == exec_pkg::JALR)
        return (a + imm) & ~exec_pkg::addr_t'(1);
    return taken ? pc + imm : pc + 64'd4;
endfunction

function automatic exec_pkg::ex_result_t compute_result(
    input exec_pkg::ex_issue_t ins,
    input exec_pkg::reg_t a,
    input exec_pkg::reg_t b
);
    exec_pkg::ex_result_t r;
    exec_pkg::reg_t imm;
    logic [31:0] w;
    logic taken;
    r = '0;
    w = '0;
    imm = ins.imm;
    r.op = ins.op;
    r.rd = ins.rd;
    r.store_value = b;
    case (ins.op)
        exec_pkg::ADD:   r.alu_result = a + b;
        exec_pkg::SUB:   r.alu_result = a - b;
        exec_pkg::SLL:   r.alu_result = a << b[5:0];
        exec_pkg::SLT:   r.alu_result = {63'd0, $signed(a) < $signed(b)};
        exec_pkg::SLTU:  r.alu_result = {63'd0, a < b};
        exec_pkg::XOR:   r.alu_result = a ^ b;
        exec_pkg::SRL:   r.alu_result = a >> b[5:0];
        exec_pkg::SRA:   r.alu_result = $signed(a) >>> b[5:0];
        exec_pkg::OR:    r.alu_result = a | b;
        exec_pkg::AND:   r.alu_result = a & b;
        exec_pkg::ADDI:  r.alu_result = a + imm;
        exec_pkg::SLTI:  r.alu_result = {63'd0, $signed(a) < $signed(imm)};
        exec_pkg::SLTIU: r.alu_result = {63'd0, a < imm};
        exec_pkg::XORI:  r.alu_result = a ^ imm;
        exec_pkg::ORI:   r.alu_result = a | imm;
        exec_pkg::ANDI:  r.alu_result = a & imm;
        exec_pkg::SLLI:  r.alu_result = a << imm[5:0];
        exec_pkg::SRLI:  r.alu_result = a >> imm[5:0];
        exec_pkg::SRAI:  r.alu_result = $signed(a) >>> imm[5:0];
        exec_pkg::ADDW:  w = a[31:0] + b[31:0];
        exec_pkg::SUBW:  w = a[31:0] - b[31:0];
        exec_pkg::SLLW:  w = a[31:0] << b[4:0];
        exec_pkg::SRLW:  w = a[31:0] >> b[4:0];
        exec_pkg::SRAW:  w = $signed(a[31:0]) >>> b[4:0];
        exec_pkg::ADDIW: w = a[31:0] + imm[31:0];
        exec_pkg::SLLIW: w = a[31:0] << imm[4:0];
        exec_pkg::SRLIW: w = a[31:0] >> imm[4:0];
        exec_pkg::SRAIW: w = $signed(a[31:0]) >>> imm[4:0];
        exec_pkg::LUI:   r.alu_result = imm;
        exec_pkg::AUIPC: r.alu_result = ins.pc + imm;
        exec_pkg::JAL,
        exec_pkg::JALR:  r.alu_result = ins.pc + 64'd4;
        exec_pkg::LOAD,
        exec_pkg::STORE: r.alu_result = a + imm;
        default:         r.alu_result = '0;
    endcase
    if (ins.op inside {exec_pkg::ADDW, exec_pkg::SUBW, exec_pkg::SLLW, exec_pkg::SRLW,
                       exec_pkg::SRAW, exec_pkg::ADDIW, exec_pkg::SLLIW, exec_pkg::SRLIW,
                       exec_pkg::SRAIW})
        r.alu_result = {{32{w[31]}}, w};
    r.writes_rd = !(ins.op inside {exec_pkg::OP_NOP, exec_pkg::STORE, exec_pkg::BEQ,
                                   exec_pkg::BNE, exec_pkg::BLT, exec_pkg::BGE,
                                   exec_pkg::BLTU, exec_pkg::BGEU});
    r.is_load = (ins.op == exec_pkg::LOAD);
    r.target = resolve_branch(ins.op, a, b, imm, ins.pc, taken);
    r.branch_taken = taken;
    return r;
endfunction

`endif

//--- sim/execute_stage_tb.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage_tb;

    localparam int SEED = 18;
    localparam int NUM_INSTR = 2000;
    localparam int READY_TIMEOUT = 4;
    localparam int DRAIN_TIMEOUT = 10;

    typedef struct packed {
        logic [31:0] due;
        exec_pkg::ex_result_t value;
    } expect_t;

    logic clk;
    logic reset;
    logic issue_valid;
    exec_pkg::ex_issue_t issue;
    exec_pkg::bypass_t alu_fwd;
    exec_pkg::bypass_t mem_fwd;
    exec_pkg::bypass_t wb_fwd;
    exec_pkg::reg_t mem_data;
    logic branch_flush;
    logic syscall_flush;
    logic issue_ready;
    exec_pkg::ex_result_t result;

    expect_t expect_q[$];
    logic [31:0] cycle = '0;
    logic stalled;
    logic checking;
    int accepted_count;

    `include "exec_model.svh"

    execute_stage u_execute_stage (
        .clk           (clk),
        .reset         (reset),
        .issue_valid   (issue_valid),
        .issue         (issue),
        .alu_fwd       (alu_fwd),
        .mem_fwd       (mem_fwd),
        .wb_fwd        (wb_fwd),
        .mem_data      (mem_data),
        .branch_flush  (branch_flush),
        .syscall_flush (syscall_flush),
        .issue_ready   (issue_ready),
        .result        (result)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle <= cycle + 32'd1;
    end

    task automatic abort_run(input string why);
        $display("ERROR at %0t: %s", $time, why);
        $display("*** TEST FAILED ***");
        $fatal(1, "run aborted");
    endtask

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got == exp)
        else
        begin
            $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_result(input exec_pkg::ex_result_t exp);
        check_field("result.op", 64'(result.op), 64'(exp.op));
        check_field("result.rd", 64'(result.rd), 64'(exp.rd));
        check_field("result.alu_result", result.alu_result, exp.alu_result);
        check_field("result.store_value", result.store_value, exp.store_value);
        check_field("result.target", result.target, exp.target);
        check_field("result.writes_rd", 64'(result.writes_rd), 64'(exp.writes_rd));
        check_field("result.is_load", 64'(result.is_load), 64'(exp.is_load));
        check_field("result.branch_taken", 64'(result.branch_taken), 64'(exp.branch_taken));
    endtask

    function automatic exec_pkg::reg_t rand_word();
        return {$urandom, $urandom};
    endfunction

    // Only x0..x3, so register matches are common
    function automatic exec_pkg::regno_t pick_reg();
        return exec_pkg::regno_t'($urandom_range(3, 0));
    endfunction

    function automatic exec_pkg::bypass_t random_bypass();
        exec_pkg::bypass_t b;
        b.rd = pick_reg();
        b.writes_rd = ($urandom_range(1, 0) == 1);
        b.is_load = ($urandom_range(3, 0) == 0);
        b.result = rand_word();
        return b;
    endfunction

    task automatic drive_new_instruction();
        exec_pkg::ex_issue_t ins;
        logic [31:0] r;
        ins.op = exec_pkg::alu_op_e'(6'($urandom_range(40, 0)));
        ins.rd = pick_reg();
        ins.rs1 = pick_reg();
        ins.rs2 = pick_reg();
        ins.rs1_value = rand_word();
        // Equal operands now and then so BEQ and BGE see ties
        ins.rs2_value = ($urandom_range(3, 0) == 0) ? ins.rs1_value : rand_word();
        r = $urandom;
        ins.imm = {{52{r[11]}}, r[11:0]};
        r = $urandom;
        ins.pc = {32'd0, r[31:2], 2'b00};
        issue <= ins;
        issue_valid <= ($urandom_range(7, 0) != 0);
        alu_fwd <= random_bypass();
        mem_fwd <= random_bypass();
        wb_fwd <= random_bypass();
        mem_data <= rand_word();
        branch_flush <= ($urandom_range(31, 0) == 0);
        syscall_flush <= ($urandom_range(31, 0) == 0);
    endtask

    // Stalled instruction stays put while the later stages move on
    task automatic advance_pipeline();
        exec_pkg::bypass_t bubble;
        bubble = '0;
        bubble.rd = pick_reg();
        // Half the time the views still show the load one ahead
        if ($urandom_range(1, 0) == 0)
        begin
            wb_fwd <= mem_fwd;
            mem_fwd <= alu_fwd;
            alu_fwd <= bubble;
        end
        mem_data <= rand_word();
        branch_flush <= ($urandom_range(31, 0) == 0);
        syscall_flush <= ($urandom_range(31, 0) == 0);
    endtask

    task automatic predict_cycle(output logic slot_done);
        logic load_use;
        logic exp_ready;
        logic accept;
        exec_pkg::reg_t a;
        exec_pkg::reg_t b;
        expect_t item;
        load_use = has_load_use(issue, alu_fwd);
        exp_ready = !(load_use && !stalled);
        check_field("issue_ready", 64'(issue_ready), 64'(exp_ready));
        accept = issue_valid && exp_ready;
        item.due = cycle + 32'd1;
        item.value = '0;
        if (syscall_flush || (accept && branch_flush))
            expect_q.push_back(item);
        else if (accept)
        begin
            a = select_operand(issue.rs1, issue.rs1_value, alu_fwd, mem_fwd, wb_fwd, mem_data);
            b = select_operand(issue.rs2, issue.rs2_value, alu_fwd, mem_fwd, wb_fwd, mem_data);
            item.value = compute_result(issue, a, b);
            expect_q.push_back(item);
        end
        if (syscall_flush || branch_flush || accept)
            stalled = 1'b0;
        else if (issue_valid && load_use)
            stalled = 1'b1;
        if (accept)
            accepted_count++;
        slot_done = !issue_valid || accept;
    endtask

    initial
    begin : stimulus
        int wait_cycles;
        logic slot_done;
        void'($urandom(SEED));
        reset <= 1'b1;
        issue_valid <= 1'b0;
        issue <= '0;
        alu_fwd <= '0;
        mem_fwd <= '0;
        wb_fwd <= '0;
        mem_data <= '0;
        branch_flush <= 1'b0;
        syscall_flush <= 1'b0;
        stalled = 1'b0;
        checking = 1'b0;
        accepted_count = 0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_field("issue_ready", 64'(issue_ready), 64'd1);
        check_result('0);
        checking = 1'b1;
        slot_done = 1'b1;
        wait_cycles = 0;
        while (accepted_count < NUM_INSTR)
        begin
            @(posedge clk);
            if (slot_done)
                drive_new_instruction();
            else
                advance_pipeline();
            @(negedge clk);
            predict_cycle(slot_done);
            wait_cycles = slot_done ? 0 : wait_cycles + 1;
            if (wait_cycles > READY_TIMEOUT)
                abort_run("the execute stage never became ready");
        end
        wait_cycles = 0;
        while (expect_q.size() != 0)
        begin
            @(negedge clk);
            wait_cycles++;
            if (wait_cycles > DRAIN_TIMEOUT)
                abort_run("expected results were left unchecked");
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

    // Result must hold between updates and take each expected value on time
    initial
    begin : compare
        exec_pkg::ex_result_t held;
        expect_t item;
        held = '0;
        forever
        begin
            @(negedge clk);
            if (checking)
            begin
                if (expect_q.size() != 0 && expect_q[0].due == cycle)
                begin
                    item = expect_q.pop_front();
                    held = item.value;
                end
                check_result(held);
            end
        end
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+sim
source/exec_pkg.sv
source/operand_forward.sv
source/int_alu.sv
source/branch_unit.sv
source/ex_mem_register.sv
source/execute_stage.sv
sim/execute_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sources.f --top-module execute_stage_tb \
    && ./obj_dir/Vexecute_stage_tb > sim.log 2>&1 \
    || echo "build or simulation did not complete" >> sim.log
cat sim.log
# Any failure line fails the run, and a clean run must have reached the end
grep -q "TEST FAILED" sim.log && exit 1 || grep -q "TEST PASSED" sim.log
